// File: design/cpu_isa_pkg.sv
/*
  Instruction set definitions for the 16-bit load/store core.
  Opcode 0x7 is unassigned and decodes as a no-op.
*/
package cpu_isa_pkg;

  // Data and instruction word
  typedef logic [15:0] word_t;
  // Byte address, bit 0 ignored by the memories
  typedef logic [15:0] addr_t;
  // Register index
  typedef logic [3:0] reg_idx_t;

  // Opcodes in bits 15:12
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_XOR = 4'h2,
    OP_AND = 4'h3,
    OP_SLL = 4'h4,
    OP_SRA = 4'h5,
    OP_ROR = 4'h6,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_LLB = 4'hA,
    OP_LHB = 4'hB,
    OP_B   = 4'hC,
    OP_PCS = 4'hD,
    OP_NOP = 4'hE,
    OP_HLT = 4'hF
  } opcode_e;

  // Branch conditions in bits 11:9
  typedef enum logic [2:0] {
    COND_NE = 3'b000,
    COND_EQ = 3'b001,
    COND_GT = 3'b010,
    COND_LT = 3'b011,
    COND_GE = 3'b100,
    COND_LE = 3'b101,
    COND_OV = 3'b110,
    COND_UN = 3'b111
  } cond_e;

  // Common register-form layout
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
  } instr_t;

  // 512 words per memory
  localparam int MEM_WORDS_LOG2 = 9;
  localparam addr_t RESET_PC = 16'h0000;

endpackage

// File: design/cpu_ctrl_pkg.sv
/*
  Control word and ALU definitions shared by decode and datapath.
  Flag enables reuse the flag struct, one bit per flag.
*/
package cpu_ctrl_pkg;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_XOR  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_SLL  = 3'd4,
    ALU_SRA  = 3'd5,
    ALU_ROR  = 3'd6,
    ALU_BYTE = 3'd7
  } alu_op_e;

  // Zero, overflow, negative
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  //////////////////////////////
  // Decoded control, 16 bits
  //////////////////////////////
  typedef struct packed {
    logic    reg_write;
    // Second operand is an immediate
    logic    alu_src_imm;
    alu_op_e alu_op;
    // Per-flag load enables
    flags_t  flag_en;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    branch;
    // Write-back of PC+2
    logic    pcs;
    logic    halt;
    // LHB rather than LLB
    logic    byte_high;
    // First source is rd (byte loads)
    logic    rd_as_src;
  } ctrl_t;

endpackage

// File: design/cpu_control.sv
/*
  Pure combinational decode, one control word per opcode.
  Unassigned opcodes behave as NOP.
*/
`timescale 1ns/1ps

module cpu_control (
  input  cpu_isa_pkg::opcode_e opcode,
  output cpu_ctrl_pkg::ctrl_t  ctrl
);

  always_comb begin
    // Defaults give a no-op
    ctrl = '0;
    ctrl.alu_op = cpu_ctrl_pkg::ALU_ADD;
    case (opcode)
      cpu_isa_pkg::OP_ADD: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = cpu_ctrl_pkg::ALU_ADD;
        ctrl.flag_en = 3'b111;
      end
      cpu_isa_pkg::OP_SUB: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = cpu_ctrl_pkg::ALU_SUB;
        ctrl.flag_en = 3'b111;
      end
      // Logic ops touch Z only
      cpu_isa_pkg::OP_XOR: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = cpu_ctrl_pkg::ALU_XOR;
        ctrl.flag_en.z = 1'b1;
      end
      cpu_isa_pkg::OP_AND: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = cpu_ctrl_pkg::ALU_AND;
        ctrl.flag_en.z = 1'b1;
      end
      // Shifts by 4-bit immediate
      cpu_isa_pkg::OP_SLL, cpu_isa_pkg::OP_SRA, cpu_isa_pkg::OP_ROR: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.flag_en.z = 1'b1;
        if (opcode == cpu_isa_pkg::OP_SLL) ctrl.alu_op = cpu_ctrl_pkg::ALU_SLL;
        else if (opcode == cpu_isa_pkg::OP_SRA) ctrl.alu_op = cpu_ctrl_pkg::ALU_SRA;
        else ctrl.alu_op = cpu_ctrl_pkg::ALU_ROR;
      end
      // Address is base plus offset
      cpu_isa_pkg::OP_LW: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      cpu_isa_pkg::OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      cpu_isa_pkg::OP_LLB, cpu_isa_pkg::OP_LHB: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op = cpu_ctrl_pkg::ALU_BYTE;
        ctrl.rd_as_src = 1'b1;
        ctrl.byte_high = (opcode == cpu_isa_pkg::OP_LHB);
      end
      cpu_isa_pkg::OP_B:   ctrl.branch = 1'b1;
      cpu_isa_pkg::OP_PCS: begin
        ctrl.reg_write = 1'b1;
        ctrl.pcs = 1'b1;
      end
      cpu_isa_pkg::OP_HLT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: design/cpu_alu.sv
/*
  Combinational ALU. Shift amounts use b[3:0] only.
  Flags are produced for every op; the control word picks which load.
*/
`timescale 1ns/1ps

module cpu_alu (
  input  cpu_isa_pkg::word_t    a,
  input  cpu_isa_pkg::word_t    b,
  input  cpu_ctrl_pkg::alu_op_e op,
  input  logic                  byte_high,
  output cpu_isa_pkg::word_t    result,
  output cpu_ctrl_pkg::flags_t  flags
);

  cpu_isa_pkg::word_t sum;
  cpu_isa_pkg::word_t diff;
  // Doubled word for rotate
  logic [31:0]        rot;
  logic               add_ovf;
  logic               sub_ovf;

  // Wrapping add and subtract
  assign sum  = a + b;
  assign diff = a - b;
  assign rot  = {a, a} >> b[3:0];

  // Signed overflow
  assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

  always_comb begin
    case (op)
      cpu_ctrl_pkg::ALU_ADD: result = sum;
      cpu_ctrl_pkg::ALU_SUB: result = diff;
      cpu_ctrl_pkg::ALU_XOR: result = a ^ b;
      cpu_ctrl_pkg::ALU_AND: result = a & b;
      cpu_ctrl_pkg::ALU_SLL: result = a << b[3:0];
      cpu_ctrl_pkg::ALU_SRA: result = $signed(a) >>> b[3:0];
      cpu_ctrl_pkg::ALU_ROR: result = rot[15:0];
      // Byte merge for LLB/LHB
      default: begin
        if (byte_high) result = {b[7:0], a[7:0]};
        else result = {a[15:8], b[7:0]};
      end
    endcase
  end

  always_comb begin
    flags.z = (result == '0);
    flags.n = result[15];
    // V only meaningful for add/sub
    case (op)
      cpu_ctrl_pkg::ALU_ADD: flags.v = add_ovf;
      cpu_ctrl_pkg::ALU_SUB: flags.v = sub_ovf;
      default:               flags.v = 1'b0;
    endcase
  end

endmodule

// File: design/cpu_register_file.sv
/*
  Sixteen registers, two async read ports, one write port.
  Read during write returns the old value. Register 0 reads as zero.
*/
`timescale 1ns/1ps

module cpu_register_file (
  input  logic                  clk,
  input  logic                  rst,
  input  cpu_isa_pkg::reg_idx_t src1,
  input  cpu_isa_pkg::reg_idx_t src2,
  input  cpu_isa_pkg::reg_idx_t dst,
  input  logic                  write,
  input  cpu_isa_pkg::word_t    dst_data,
  output cpu_isa_pkg::word_t    src1_data,
  output cpu_isa_pkg::word_t    src2_data
);

  cpu_isa_pkg::word_t regs [16];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (write && (dst != '0)) begin
      // Writes to r0 dropped
      regs[dst] <= dst_data;
    end
  end

  // r0 hard-wired
  assign src1_data = (src1 == '0) ? '0 : regs[src1];
  assign src2_data = (src2 == '0) ? '0 : regs[src2];

endmodule

// File: design/cpu_flag_register.sv
/*
  Z, V, N storage with per-flag load enables.
  Branch condition is evaluated on the stored flags only.
*/
`timescale 1ns/1ps

module cpu_flag_register (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_ctrl_pkg::flags_t en,
  input  cpu_ctrl_pkg::flags_t next_flags,
  input  cpu_isa_pkg::cond_e   cond,
  output logic                 branch_taken
);

  cpu_ctrl_pkg::flags_t flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      // Each flag loads on its own enable
      if (en.z) flags.z <= next_flags.z;
      if (en.v) flags.v <= next_flags.v;
      if (en.n) flags.n <= next_flags.n;
    end
  end

  //////////////////////////////
  // Condition check
  //////////////////////////////
  always_comb begin
    case (cond)
      cpu_isa_pkg::COND_NE: branch_taken = !flags.z;
      cpu_isa_pkg::COND_EQ: branch_taken = flags.z;
      cpu_isa_pkg::COND_GT: branch_taken = !flags.z && !flags.n;
      cpu_isa_pkg::COND_LT: branch_taken = flags.n;
      cpu_isa_pkg::COND_GE: branch_taken = !flags.n;
      cpu_isa_pkg::COND_LE: branch_taken = flags.z || flags.n;
      cpu_isa_pkg::COND_OV: branch_taken = flags.v;
      // Unconditional
      default:              branch_taken = 1'b1;
    endcase
  end

endmodule

// File: design/cpu_memory.sv
/*
  Word memory, combinational read, write on the rising edge.
  Byte address, bit 0 ignored; upper bits beyond depth wrap.
  Contents are not reset.
*/
`timescale 1ns/1ps

module cpu_memory (
  input  logic               clk,
  input  cpu_isa_pkg::addr_t addr,
  input  cpu_isa_pkg::word_t wdata,
  input  logic               write,
  output cpu_isa_pkg::word_t rdata
);

  localparam int WORDS = 2 ** cpu_isa_pkg::MEM_WORDS_LOG2;

  cpu_isa_pkg::word_t                      mem [WORDS];
  // Word index from byte address
  logic [cpu_isa_pkg::MEM_WORDS_LOG2-1:0] idx;

  assign idx = addr[cpu_isa_pkg::MEM_WORDS_LOG2:1];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[idx] <= wdata;
    end
  end

  // Same-cycle read
  assign rdata = mem[idx];

endmodule

// File: design/cpu_pc_unit.sv
/*
  Program counter with next-PC and branch adders plus halt latch.
  Offset arrives sign-extended and doubled; target is PC+2 + offset.
  Once halted the PC holds until rst.
*/
`timescale 1ns/1ps

module cpu_pc_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               branch,
  input  logic               branch_taken,
  input  cpu_isa_pkg::word_t offset,
  input  logic               halt,
  output cpu_isa_pkg::addr_t pc,
  output cpu_isa_pkg::addr_t pc_plus2,
  output logic               hlt
);

  cpu_isa_pkg::addr_t target;
  cpu_isa_pkg::addr_t pc_next;

  // Sequential and branch adders
  assign pc_plus2 = pc + 16'd2;
  assign target   = pc_plus2 + offset;

  always_comb begin
    if (halt || hlt) begin
      // Park on the HLT address
      pc_next = pc;
    end else if (branch && branch_taken) begin
      pc_next = target;
    end else begin
      pc_next = pc_plus2;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc  <= cpu_isa_pkg::RESET_PC;
      hlt <= 1'b0;
    end else begin
      pc <= pc_next;
      // Sticky until reset
      if (halt) hlt <= 1'b1;
    end
  end

endmodule

// File: design/cpu.sv
/*
  Single-cycle 16-bit core, one instruction per clock.
  Instruction memory is loaded through prog_* only while rst is high.
  Separate instruction and data memories, 512 words each.
*/
`timescale 1ns/1ps

module cpu (
  input  logic               clk,
  input  logic               rst,
  input  logic               prog_we,
  input  cpu_isa_pkg::addr_t prog_addr,
  input  cpu_isa_pkg::word_t prog_data,
  output logic               hlt,
  output cpu_isa_pkg::addr_t pc
);

  cpu_isa_pkg::word_t       inst_word;
  cpu_isa_pkg::instr_t      inst;
  cpu_isa_pkg::addr_t       imem_addr;
  cpu_ctrl_pkg::ctrl_t      ctrl;
  cpu_isa_pkg::reg_idx_t    src1_idx;
  cpu_isa_pkg::reg_idx_t    src2_idx;
  cpu_isa_pkg::word_t       src1_data;
  cpu_isa_pkg::word_t       src2_data;
  cpu_isa_pkg::word_t       imm;
  cpu_isa_pkg::word_t       mem_off;
  cpu_isa_pkg::word_t       br_off;
  cpu_isa_pkg::word_t       alu_b;
  cpu_isa_pkg::word_t       alu_result;
  cpu_ctrl_pkg::flags_t     alu_flags;
  cpu_isa_pkg::word_t       dmem_rdata;
  cpu_isa_pkg::word_t       wb_data;
  cpu_isa_pkg::addr_t       pc_plus2;
  logic                     branch_taken;

  //////////////////////////////
  // Fetch
  //////////////////////////////
  // Program port owns the imem during reset
  assign imem_addr = rst ? prog_addr : pc;

  cpu_memory u_imem (.clk(clk), .addr(imem_addr), .wdata(prog_data),
                     .write(prog_we && rst), .rdata(inst_word));

  assign inst = cpu_isa_pkg::instr_t'(inst_word);

  //////////////////////////////
  // Decode
  //////////////////////////////
  cpu_control u_control (.opcode(inst.opcode), .ctrl(ctrl));

  // Byte loads read rd, stores send rd as data
  assign src1_idx = ctrl.rd_as_src ? inst.rd : inst.rs;
  assign src2_idx = ctrl.mem_write ? inst.rd : inst.rt;

  cpu_register_file u_regs (.clk(clk), .rst(rst), .src1(src1_idx), .src2(src2_idx),
                            .dst(inst.rd), .write(ctrl.reg_write), .dst_data(wb_data),
                            .src1_data(src1_data), .src2_data(src2_data));

  // Offsets sign-extended and scaled by 2
  assign mem_off = {{11{inst.rt[3]}}, inst.rt, 1'b0};
  assign br_off  = {{6{inst_word[8]}}, inst_word[8:0], 1'b0};

  //////////////////////////////
  // Execute
  //////////////////////////////
  always_comb begin
    if (ctrl.mem_read || ctrl.mem_write) imm = mem_off;
    else if (ctrl.alu_op == cpu_ctrl_pkg::ALU_BYTE) imm = {8'h00, inst_word[7:0]};
    else imm = {12'h000, inst.rt};
  end

  assign alu_b = ctrl.alu_src_imm ? imm : src2_data;

  cpu_alu u_alu (.a(src1_data), .b(alu_b), .op(ctrl.alu_op), .byte_high(ctrl.byte_high),
                 .result(alu_result), .flags(alu_flags));

  cpu_flag_register u_flags (.clk(clk), .rst(rst), .en(ctrl.flag_en),
                             .next_flags(alu_flags),
                             .cond(cpu_isa_pkg::cond_e'(inst_word[11:9])),
                             .branch_taken(branch_taken));

  cpu_pc_unit u_pc (.clk(clk), .rst(rst), .branch(ctrl.branch),
                    .branch_taken(branch_taken), .offset(br_off), .halt(ctrl.halt),
                    .pc(pc), .pc_plus2(pc_plus2), .hlt(hlt));

  //////////////////////////////
  // Memory and write-back
  //////////////////////////////
  cpu_memory u_dmem (.clk(clk), .addr(alu_result), .wdata(src2_data),
                     .write(ctrl.mem_write && !rst), .rdata(dmem_rdata));

  always_comb begin
    if (ctrl.pcs) wb_data = pc_plus2;
    else if (ctrl.mem_to_reg) wb_data = dmem_rdata;
    else wb_data = alu_result;
  end

endmodule

// File: verif/cpu_props.sv
/*
  Bound checks on PC alignment and halt behavior of the core.
  All properties are disabled while rst is high.
*/
`timescale 1ns/1ps

module cpu_props (
  input logic               clk,
  input logic               rst,
  input logic               hlt,
  input cpu_isa_pkg::addr_t pc,
  input logic               halt,
  input logic               branch,
  input logic               branch_taken,
  input cpu_isa_pkg::word_t br_off
);

  logic self_branch;

  // Taken branch back onto itself, offset of -2 bytes
  assign self_branch = branch && branch_taken && (br_off == 16'hFFFE);

  // Byte address of a word, never odd
  pc_even: assert property (@(posedge clk) disable iff (rst) !pc[0])
    else $error("pc is odd");

  // Halt is sticky and parks the PC
  hlt_hold: assert property (@(posedge clk) disable iff (rst)
    hlt |=> hlt && $stable(pc))
    else $error("hlt dropped or pc moved after halt");

  // One instruction retired per edge
  pc_moves: assert property (@(posedge clk) disable iff (rst)
    !hlt && !halt && !self_branch |=> pc != $past(pc))
    else $error("pc did not advance while running");

endmodule

// File: verif/cpu_tb.sv
/*
  Testbench for the single-cycle core. Each table row is a short program
  whose result steers it onto a known HLT address. Rows hold at most 24 words;
  a few random HLT-free words are written past the end of each program.
*/
`timescale 1ns/1ps

module cpu_tb;

  localparam int MAX_WORDS    = 24;
  localparam int FILL_WORDS   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int HLT_TIMEOUT  = 500;
  localparam int HOLD_CYCLES  = 20;

  // One program with its expected outcome
  typedef struct packed {
    logic [4:0]              len;
    logic [MAX_WORDS*16-1:0] words;
    cpu_isa_pkg::addr_t      halt_pc;
    logic [7:0]              count;
  } prog_row_t;

  logic               clk;
  logic               rst;
  logic               prog_we;
  cpu_isa_pkg::addr_t prog_addr;
  cpu_isa_pkg::word_t prog_data;
  logic               hlt;
  cpu_isa_pkg::addr_t pc;

  prog_row_t rows[$];
  int        errors;
  int        timeouts;

  cpu u_dut (.clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
             .prog_data(prog_data), .hlt(hlt), .pc(pc));

  bind cpu cpu_props u_props (.clk(clk), .rst(rst), .hlt(hlt), .pc(pc),
                              .halt(ctrl.halt), .branch(ctrl.branch),
                              .branch_taken(branch_taken), .br_off(br_off));

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////
  // Program table
  //////////////////////////////
  // Words given first to last, right-aligned in the vector
  task automatic add_row(input logic [4:0] len, input cpu_isa_pkg::addr_t halt_pc,
                         input logic [7:0] count, input logic [MAX_WORDS*16-1:0] words);
    prog_row_t row;
    row.len = len;
    row.words = words;
    row.halt_pc = halt_pc;
    row.count = count;
    rows.push_back(row);
  endtask

  task automatic build_table();
    // ADD, SUB, XOR, AND on LLB/LHB values, compared by SUB
    add_row(5'd24, 16'h002E, 8'd22,
      {16'hA134, 16'hB112, 16'hA20F, 16'hB20F, 16'h0312, 16'hA443, 16'hB421, 16'h1034,
       16'hC00D, 16'h1932, 16'h1091, 16'hC00A, 16'h2512, 16'hA63B, 16'hB61D, 16'h1056,
       16'hC005, 16'h3712, 16'hA804, 16'hB802, 16'h1078, 16'hC201, 16'hF000, 16'hF000});
    // SLL 4, SRA 3, ROR 8, SLL 0
    add_row(5'd22, 16'h002A, 8'd20,
      {16'hA181, 16'hB196, 16'h4214, 16'hA310, 16'hB368, 16'h1023, 16'hC00D, 16'h5413,
       16'hA5D0, 16'hB5F2, 16'h1045, 16'hC008, 16'h6618, 16'hA796, 16'hB781, 16'h1067,
       16'hC003, 16'h4810, 16'h2081, 16'hC201, 16'hF000, 16'hF000});
    // SW/LW with +3 and -2 word offsets, two bases
    add_row(5'd18, 16'h0022, 8'd16,
      {16'hA140, 16'hA2CD, 16'hB2AB, 16'h9213, 16'hA35A, 16'h931E, 16'h8413, 16'h851E,
       16'h1042, 16'hC006, 16'h1053, 16'hC004, 16'hA64A, 16'h876E, 16'h1072, 16'hC201,
       16'hF000, 16'hF000});
    // Conditions on zero, positive and negative results
    add_row(5'd24, 16'h002C, 8'd16,
      {16'hA105, 16'h1000, 16'hC201, 16'hF000, 16'hC801, 16'hF000, 16'hCA01, 16'hF000,
       16'hC00E, 16'hC40D, 16'hC60C, 16'h1010, 16'hC001, 16'hF000, 16'hC401, 16'hF000,
       16'hC206, 16'hCA05, 16'h1001, 16'hC601, 16'hF000, 16'hC801, 16'hF000, 16'hF000});
    // OV after overflowing ADD, kept across XOR, then UN
    add_row(5'd15, 16'h001C, 8'd10,
      {16'h1000, 16'hCC0B, 16'hA2FF, 16'hB27F, 16'h0022, 16'hCC01, 16'hF000, 16'h2022,
       16'hCC01, 16'hF000, 16'hC201, 16'hF000, 16'hCE01, 16'hF000, 16'hF000});
    // PCS and writes to r0
    add_row(5'd13, 16'h0018, 8'd11,
      {16'hA055, 16'hB055, 16'h0100, 16'hC007, 16'hD200, 16'hA30A, 16'h1023, 16'hC003,
       16'hD000, 16'h1020, 16'hC401, 16'hF000, 16'hF000});
    // NOP then HLT, word after HLT never runs
    add_row(5'd4, 16'h0004, 8'd2, {16'hE000, 16'hA101, 16'hF000, 16'hA102});
  endtask

  //////////////////////////////
  // Loading and running
  //////////////////////////////
  // Any opcode but HLT
  function automatic cpu_isa_pkg::word_t random_filler();
    return {4'($urandom_range(14, 0)), 12'($urandom)};
  endfunction

  task automatic load_program(input prog_row_t row);
    int n;
    n = int'(row.len);
    rst = 1'b1;
    for (int i = 0; i < n + FILL_WORDS; i++) begin
      @(negedge clk);
      prog_we = 1'b1;
      prog_addr = cpu_isa_pkg::addr_t'(2 * i);
      if (i < n)
        prog_data = row.words[16 * (n - 1 - i) +: 16];
      else
        prog_data = random_filler();
    end
    @(negedge clk);
    prog_we = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
  endtask

  // Halted core must stay parked
  task automatic check_hold(input int r, input cpu_isa_pkg::addr_t halt_pc);
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(negedge clk);
      assert (hlt === 1'b1) else begin
        $display("[ERROR] prog %0d hlt: got 0x%h, expected 0x1", r, hlt);
        errors++;
      end
      assert (pc === halt_pc) else begin
        $display("[ERROR] prog %0d pc after halt: got 0x%h, expected 0x%h", r, pc, halt_pc);
        errors++;
      end
    end
  endtask

  task automatic run_row(input int r);
    prog_row_t row;
    int        edges;
    bit        done;
    row = rows[r];
    load_program(row);
    // Release on a falling edge
    rst = 1'b0;
    edges = 0;
    done = 1'b0;
    while (!done && edges < HLT_TIMEOUT) begin
      @(negedge clk);
      edges++;
      if (hlt === 1'b1)
        done = 1'b1;
    end
    if (!done) begin
      $display("Timeout: program %0d did not halt within %0d cycles", r, HLT_TIMEOUT);
      timeouts++;
    end else begin
      assert (pc === row.halt_pc) else begin
        $display("[ERROR] prog %0d pc: got 0x%h, expected 0x%h", r, pc, row.halt_pc);
        errors++;
      end
      // N instructions give hlt after N+1 edges
      assert (edges - 1 == int'(row.count)) else begin
        $display("[ERROR] prog %0d instr_count: got 0x%h, expected 0x%h",
                 r, edges - 1, row.count);
        errors++;
      end
      check_hold(r, row.halt_pc);
    end
  endtask

  initial begin
    rst = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    errors = 0;
    timeouts = 0;
    void'($urandom(29));
    build_table();
    for (int r = 0; r < rows.size(); r++) begin
      run_row(r);
    end
    $display("Programs: %0d, errors: %0d, timeouts: %0d", rows.size(), errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// File: src.f
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_control.sv
design/cpu_alu.sv
design/cpu_register_file.sv
design/cpu_flag_register.sv
design/cpu_memory.sv
design/cpu_pc_unit.sv
design/cpu.sv
verif/cpu_props.sv
verif/cpu_tb.sv
